/* Makefile */
# Verilator build and regression run for the out-of-order engine
SIM = obj_dir/Vtb_ooo_engine

.PHONY: all run check clean

all: run

$(SIM): ooo_engine.f $(wildcard logic/*.sv logic/*.svh sim/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_ooo_engine -f ooo_engine.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -qx "Regression passed" sim.log

check:
	grep -qx "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* logic/decode_unit.sv */
// Decoder for one reorder entry at a time
// Latches the picked word on dec_issue, then holds a decoded-fields
// update request until the arbiter grants it
`timescale 1ns/1ps
`default_nettype none
`include "ooo_settings.svh"

module decode_unit
	import ooo_pkg::*;
(
	input  wire                clk,
	input  wire                rst_n,
	input  wire                dec_issue,
	input  wire [`IDX_W-1:0]   dec_idx,
	input  wire [15:0]         dec_instr,
	input  wire                grant,
	output logic               dec_ready,
	output logic               upd_req,
	output logic [`IDX_W-1:0]  upd_idx,
	output logic [`UPD_W-1:0]  upd_data
);

	instr_u                instr_q;
	logic                  busy;
	logic                  we;
	logic                  is_mem;
	logic [2:0]            dst;
	logic [2:0]            src_b;
	logic [`NUM_REGS-1:0]  src_mask;
	logic [`DATA_W-1:0]    offset;

	// Busy from issue until the update goes out
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			busy <= 1'b0;
		else if (dec_issue)
			busy <= 1'b1;
		else if (grant)
			busy <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (dec_issue) begin
			upd_idx <= dec_idx;
			instr_q <= dec_instr;
		end
	end

	assign dec_ready = !busy;
	assign upd_req   = busy;

	// Field extraction per opcode, NOP codes keep the defaults
	// Dest bits are the same in both formats
	always_comb begin
		offset   = {{(`DATA_W-7){instr_q.imm_fmt.offset[6]}}, instr_q.imm_fmt.offset};
		dst      = instr_q.imm_fmt.reg_field;
		src_b    = '0;
		we       = 1'b0;
		is_mem   = 1'b0;
		src_mask = `NUM_REGS'(1) << instr_q.imm_fmt.src_a;
		case (instr_q.reg_fmt.opcode)
			ADDI: we = 1'b1;
			ADD, SUB, XOR: begin
				src_b    = instr_q.reg_fmt.src_b;
				we       = 1'b1;
				src_mask = src_mask | (`NUM_REGS'(1) << instr_q.reg_fmt.src_b);
			end
			LOAD: begin
				we     = 1'b1;
				is_mem = 1'b1;
			end
			// Store data register rides in the src_b slot
			STORE: begin
				dst      = '0;
				src_b    = instr_q.imm_fmt.reg_field;
				is_mem   = 1'b1;
				src_mask = src_mask | (`NUM_REGS'(1) << instr_q.imm_fmt.reg_field);
			end
			default: begin
				dst      = '0;
				src_mask = '0;
			end
		endcase
	end

	assign upd_data = {instr_q.reg_fmt.opcode, dst, instr_q.reg_fmt.src_a, src_b, offset,
		we, is_mem, src_mask};

endmodule

`default_nettype wire

/* logic/execute_unit.sv */
// Executor with the architectural register file and data memory
// Latches the picked entry's fields on ex_issue and requests a result
// update the next cycle; retirements write the register file
`timescale 1ns/1ps
`default_nettype none
`include "ooo_settings.svh"

module execute_unit
	import ooo_pkg::*;
(
	input  wire                clk,
	input  wire                rst_n,
	input  wire                ex_issue,
	input  wire [`IDX_W-1:0]   ex_idx,
	input  wire [`EXF_W-1:0]   ex_fields,
	input  wire                grant,
	input  wire                retire_valid,
	input  wire [2:0]          retire_dst,
	input  wire                retire_we,
	input  wire [`DATA_W-1:0]  retire_data,
	output logic               ex_ready,
	output logic               upd_req,
	output logic [`IDX_W-1:0]  upd_idx,
	output logic [`UPD_W-1:0]  upd_data
);

	localparam int MA = $clog2(`DMEM_WORDS);

	logic [`DATA_W-1:0] regs [`NUM_REGS];
	logic [`DATA_W-1:0] dmem [`DMEM_WORDS];
	logic               busy;
	logic [`EXF_W-1:0]  fields_q;
	opcode_e            op;
	logic [`DATA_W-1:0] op_a;
	logic [`DATA_W-1:0] op_b;
	logic [`DATA_W-1:0] result;
	logic [MA-1:0]      addr;

	// ========================================
	// Architectural state and busy flag
	// ========================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			for (int i = 0; i < `NUM_REGS; i++)
				regs[i] <= '0;
			for (int i = 0; i < `DMEM_WORDS; i++)
				dmem[i] <= '0;
		end else begin
			if (ex_issue)
				busy <= 1'b1;
			else if (grant)
				busy <= 1'b0;
			// Results land here only at retirement
			if (retire_valid && retire_we)
				regs[retire_dst] <= retire_data;
			// Store commits once, on its granted update
			if (grant && op == STORE)
				dmem[addr] <= op_b;
		end
	end

	always_ff @(posedge clk) begin
		if (ex_issue) begin
			upd_idx  <= ex_idx;
			fields_q <= ex_fields;
		end
	end

	assign ex_ready = !busy;
	assign upd_req  = busy;

	// ========================================
	// Operands and ALU
	// ========================================
	// Older writers have retired by now, so the file holds final values
	assign op   = opcode_e'(fields_q[`DATA_W+9 +: 3]);
	assign op_a = regs[fields_q[`DATA_W+3 +: 3]];
	assign op_b = regs[fields_q[`DATA_W +: 3]];
	// Address wraps within the memory depth
	assign addr = op_a[MA-1:0] + fields_q[MA-1:0];

	always_comb begin
		case (op)
			ADDI:    result = op_a + fields_q[`DATA_W-1:0];
			ADD:     result = op_a + op_b;
			SUB:     result = op_a - op_b;
			XOR:     result = op_a ^ op_b;
			LOAD:    result = dmem[addr];
			STORE:   result = op_b;
			default: result = '0;
		endcase
	end

	assign upd_data = {{(`UPD_W-`DATA_W){1'b0}}, result};

endmodule

`default_nettype wire

/* logic/ooo_engine_top.sv */
// Top of the out-of-order engine
// Wires the reorder store, stage scheduler, decoder, executor and update arbiter
`timescale 1ns/1ps
`default_nettype none
`include "ooo_settings.svh"

module ooo_engine_top
	import ooo_pkg::*;
(
	input  wire                clk,
	input  wire                rst_n,
	input  wire                in_valid,
	input  wire [15:0]         in_instr,
	output wire                rob_full,
	output wire                retire_valid,
	output wire [2:0]          retire_dst,
	output wire                retire_we,
	output wire [`DATA_W-1:0]  retire_data
);

	// Entry state toward the scheduler
	wire [`ROB_ENTRIES-1:0] valid_vec, decoded_vec, executed_vec, out_vec, is_mem_vec;
	wire [`SNS_W-1:0]       sns_arr [`ROB_ENTRIES];
	wire [`NUM_REGS-1:0]    dst_mask_arr [`ROB_ENTRIES];
	wire [`NUM_REGS-1:0]    src_mask_arr [`ROB_ENTRIES];
	wire [`SNS_W-1:0]       head_sns;
	// Picks and pulses
	wire [`IDX_W-1:0]       alloc_idx, dec_idx, ex_idx, retire_idx;
	wire                    dec_issue, ex_issue, retire_fire, dec_ready, ex_ready;
	wire [15:0]             dec_instr;
	wire [`EXF_W-1:0]       ex_fields;
	// Update path
	wire                    dec_req, ex_req, dec_grant, ex_grant, upd_valid;
	wire [`IDX_W-1:0]       dec_upd_idx, ex_upd_idx, upd_idx;
	wire [`UPD_W-1:0]       dec_upd_data, ex_upd_data, upd_data;
	wire upd_kind_e         upd_kind;

	rob_store u_store (
		.clk, .rst_n, .in_valid, .in_instr, .alloc_idx, .dec_issue, .dec_idx,
		.ex_issue, .ex_idx, .upd_valid, .upd_idx, .upd_kind, .upd_data,
		.retire_fire, .retire_idx, .rob_full, .valid_vec, .decoded_vec,
		.executed_vec, .out_vec, .is_mem_vec, .sns_arr, .dst_mask_arr,
		.src_mask_arr, .head_sns, .dec_instr, .ex_fields, .retire_valid,
		.retire_dst, .retire_we, .retire_data
	);

	stage_scheduler u_sched (
		.valid_vec, .decoded_vec, .executed_vec, .out_vec, .is_mem_vec, .sns_arr,
		.dst_mask_arr, .src_mask_arr, .head_sns, .dec_ready, .ex_ready, .alloc_idx,
		.dec_issue, .dec_idx, .ex_issue, .ex_idx, .retire_fire, .retire_idx
	);

	decode_unit u_dec (
		.clk, .rst_n, .dec_issue, .dec_idx, .dec_instr, .grant(dec_grant),
		.dec_ready, .upd_req(dec_req), .upd_idx(dec_upd_idx), .upd_data(dec_upd_data)
	);

	execute_unit u_ex (
		.clk, .rst_n, .ex_issue, .ex_idx, .ex_fields, .grant(ex_grant),
		.retire_valid, .retire_dst, .retire_we, .retire_data,
		.ex_ready, .upd_req(ex_req), .upd_idx(ex_upd_idx), .upd_data(ex_upd_data)
	);

	rob_update_arbiter u_arb (
		.clk, .rst_n, .dec_req, .dec_idx(dec_upd_idx), .dec_data(dec_upd_data),
		.ex_req, .ex_idx(ex_upd_idx), .ex_data(ex_upd_data), .dec_grant, .ex_grant,
		.upd_valid, .upd_idx, .upd_kind, .upd_data
	);

endmodule

`default_nettype wire

/* logic/ooo_pkg.sv */
// Shared types for the out-of-order engine
// Modules pull these in with a wildcard import in their header
`default_nettype none

package ooo_pkg;

	// ========================================
	// Opcodes
	// ========================================
	// Codes 6 and 7 are no-ops, retire with no write
	typedef enum logic [2:0] {
		ADDI  = 3'd0,
		ADD   = 3'd1,
		SUB   = 3'd2,
		XOR   = 3'd3,
		LOAD  = 3'd4,
		STORE = 3'd5
	} opcode_e;

	// ========================================
	// Instruction word, two views
	// ========================================
	// Opcode, reg_field/dst and src_a sit in the same bits in both
	typedef union packed {
		struct packed {
			opcode_e    opcode;
			logic [2:0] dst;
			logic [2:0] src_a;
			logic [2:0] src_b;
			logic [3:0] unused;
		} reg_fmt;
		struct packed {
			opcode_e    opcode;
			// Dest for ADDI and LOAD, data register for STORE
			logic [2:0] reg_field;
			logic [2:0] src_a;
			logic [6:0] offset;
		} imm_fmt;
	} instr_u;

	// Kind of report on the reorder update port
	typedef enum logic {
		UPD_DECODED  = 1'b0,
		UPD_EXECUTED = 1'b1
	} upd_kind_e;

endpackage

`default_nettype wire

/* logic/ooo_settings.svh */
// Sizing macros for the out-of-order engine
// Include after the nettype line in any file that needs widths or depths
`ifndef OOO_SETTINGS_SVH
`define OOO_SETTINGS_SVH

// Reorder buffer depth, entry index width, index that means no entry
`define ROB_ENTRIES 6
`define IDX_W       3
`define IDX_NONE    3'd7

// Datapath and architectural state
`define DATA_W      16
`define NUM_REGS    8
`define DMEM_WORDS  16
`define SNS_W       8

// Decoded fields {opcode, dst, src_a, src_b, offset}
`define EXF_W       (12 + `DATA_W)
// Update payload, decoded fields then {we, is_mem, src_mask}
`define UPD_W       (`EXF_W + 2 + `NUM_REGS)

`endif

/* logic/rob_store.sv */
// Reorder entry storage with per-entry state bits and sequence numbers
// Allocates on accepted input, records decoder and executor updates,
// and frees the oldest entry on retire_fire with registered retire outputs
`timescale 1ns/1ps
`default_nettype none
`include "ooo_settings.svh"

module rob_store
	import ooo_pkg::*;
(
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire                    in_valid,
	input  wire [15:0]             in_instr,
	input  wire [`IDX_W-1:0]       alloc_idx,
	input  wire                    dec_issue,
	input  wire [`IDX_W-1:0]       dec_idx,
	input  wire                    ex_issue,
	input  wire [`IDX_W-1:0]       ex_idx,
	input  wire                    upd_valid,
	input  wire [`IDX_W-1:0]       upd_idx,
	input  wire upd_kind_e         upd_kind,
	input  wire [`UPD_W-1:0]       upd_data,
	input  wire                    retire_fire,
	input  wire [`IDX_W-1:0]       retire_idx,
	output logic                   rob_full,
	output logic [`ROB_ENTRIES-1:0] valid_vec,
	output logic [`ROB_ENTRIES-1:0] decoded_vec,
	output logic [`ROB_ENTRIES-1:0] executed_vec,
	output logic [`ROB_ENTRIES-1:0] out_vec,
	output logic [`ROB_ENTRIES-1:0] is_mem_vec,
	output logic [`SNS_W-1:0]      sns_arr [`ROB_ENTRIES],
	output logic [`NUM_REGS-1:0]   dst_mask_arr [`ROB_ENTRIES],
	output logic [`NUM_REGS-1:0]   src_mask_arr [`ROB_ENTRIES],
	output logic [`SNS_W-1:0]      head_sns,
	output logic [15:0]            dec_instr,
	output logic [`EXF_W-1:0]      ex_fields,
	output logic                   retire_valid,
	output logic [2:0]             retire_dst,
	output logic                   retire_we,
	output logic [`DATA_W-1:0]     retire_data
);

	// Entry payload
	logic [`ROB_ENTRIES-1:0] we_r;
	logic [15:0]             instr_r  [`ROB_ENTRIES];
	logic [`EXF_W-1:0]       exf_r    [`ROB_ENTRIES];
	logic [`DATA_W-1:0]      result_r [`ROB_ENTRIES];
	logic [`SNS_W-1:0]       next_sns;
	logic                    accept;

	// Full only when every entry is live
	assign rob_full = &valid_vec;
	assign accept   = in_valid && !rob_full;

	// ========================================
	// Entry state bits and counters
	// ========================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_vec    <= '0;
			decoded_vec  <= '0;
			executed_vec <= '0;
			out_vec      <= '0;
			next_sns     <= '0;
			head_sns     <= '0;
			retire_valid <= 1'b0;
		end else begin
			retire_valid <= retire_fire;
			// New entry starts fresh with the next sequence number
			if (accept) begin
				valid_vec[alloc_idx]    <= 1'b1;
				decoded_vec[alloc_idx]  <= 1'b0;
				executed_vec[alloc_idx] <= 1'b0;
				out_vec[alloc_idx]      <= 1'b0;
				next_sns                <= next_sns + 1'b1;
			end
			// Out while a unit holds the entry
			if (dec_issue)
				out_vec[dec_idx] <= 1'b1;
			if (ex_issue)
				out_vec[ex_idx] <= 1'b1;
			if (upd_valid) begin
				out_vec[upd_idx] <= 1'b0;
				if (upd_kind == UPD_DECODED)
					decoded_vec[upd_idx] <= 1'b1;
				else
					executed_vec[upd_idx] <= 1'b1;
			end
			// Oldest leaves, head moves to the next number
			if (retire_fire) begin
				valid_vec[retire_idx] <= 1'b0;
				head_sns              <= head_sns + 1'b1;
			end
		end
	end

	// ========================================
	// Entry payload and retire outputs
	// ========================================
	always_ff @(posedge clk) begin
		if (accept) begin
			sns_arr[alloc_idx] <= next_sns;
			instr_r[alloc_idx] <= in_instr;
		end
		if (upd_valid && upd_kind == UPD_DECODED) begin
			exf_r[upd_idx]        <= upd_data[`UPD_W-1 -: `EXF_W];
			we_r[upd_idx]         <= upd_data[`NUM_REGS+1];
			is_mem_vec[upd_idx]   <= upd_data[`NUM_REGS];
			src_mask_arr[upd_idx] <= upd_data[`NUM_REGS-1:0];
		end
		if (upd_valid && upd_kind == UPD_EXECUTED)
			result_r[upd_idx] <= upd_data[`DATA_W-1:0];
		if (retire_fire) begin
			retire_dst  <= exf_r[retire_idx][`DATA_W+6 +: 3];
			retire_we   <= we_r[retire_idx];
			retire_data <= result_r[retire_idx];
		end
	end

	// Written-register mask, empty until the entry is decoded
	always_comb begin
		for (int i = 0; i < `ROB_ENTRIES; i++) begin
			if (decoded_vec[i] && we_r[i])
				dst_mask_arr[i] = `NUM_REGS'(1) << exf_r[i][`DATA_W+6 +: 3];
			else
				dst_mask_arr[i] = '0;
		end
	end

	// Read-outs for the picked entries
	assign dec_instr = instr_r[dec_idx];
	assign ex_fields = exf_r[ex_idx];

	// Only a live entry handed to a unit may be reported on
	a_upd_live: assert property (@(posedge clk) disable iff (!rst_n)
		upd_valid |-> valid_vec[upd_idx] && out_vec[upd_idx]);

endmodule

`default_nettype wire

/* logic/rob_update_arbiter.sv */
// Arbiter for the single reorder update port
// Executor wins over decoder; the loser keeps its request up
`timescale 1ns/1ps
`default_nettype none
`include "ooo_settings.svh"

module rob_update_arbiter
	import ooo_pkg::*;
(
	input  wire                clk,
	input  wire                rst_n,
	input  wire                dec_req,
	input  wire [`IDX_W-1:0]   dec_idx,
	input  wire [`UPD_W-1:0]   dec_data,
	input  wire                ex_req,
	input  wire [`IDX_W-1:0]   ex_idx,
	input  wire [`UPD_W-1:0]   ex_data,
	output logic               dec_grant,
	output logic               ex_grant,
	output logic               upd_valid,
	output logic [`IDX_W-1:0]  upd_idx,
	output upd_kind_e          upd_kind,
	output logic [`UPD_W-1:0]  upd_data
);

	// Fixed priority
	assign ex_grant  = ex_req;
	assign dec_grant = dec_req && !ex_req;
	assign upd_valid = ex_req || dec_req;

	// Kind follows the winner
	always_comb begin
		if (ex_grant) begin
			upd_idx  = ex_idx;
			upd_kind = UPD_EXECUTED;
			upd_data = ex_data;
		end else begin
			upd_idx  = dec_idx;
			upd_kind = UPD_DECODED;
			upd_data = dec_data;
		end
	end

	// Each grant lasts one cycle since the winner drops its request
	a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
		!(ex_grant && $past(ex_grant)) && !(dec_grant && $past(dec_grant)));

	// Decoder that loses keeps the same request up
	a_dec_hold: assert property (@(posedge clk) disable iff (!rst_n)
		dec_req && !dec_grant |=> dec_req && $stable(dec_idx));

endmodule

`default_nettype wire

/* logic/stage_scheduler.sv */
// Combinational picker for the reorder entries
// Chooses one entry per cycle each for allocation, decode, execute and retire
// from the entry state; age is the distance of a sequence number from head_sns
`timescale 1ns/1ps
`default_nettype none
`include "ooo_settings.svh"

module stage_scheduler (
	input  wire [`ROB_ENTRIES-1:0] valid_vec,
	input  wire [`ROB_ENTRIES-1:0] decoded_vec,
	input  wire [`ROB_ENTRIES-1:0] executed_vec,
	input  wire [`ROB_ENTRIES-1:0] out_vec,
	input  wire [`ROB_ENTRIES-1:0] is_mem_vec,
	input  wire [`SNS_W-1:0]       sns_arr [`ROB_ENTRIES],
	input  wire [`NUM_REGS-1:0]    dst_mask_arr [`ROB_ENTRIES],
	input  wire [`NUM_REGS-1:0]    src_mask_arr [`ROB_ENTRIES],
	input  wire [`SNS_W-1:0]       head_sns,
	input  wire                    dec_ready,
	input  wire                    ex_ready,
	output logic [`IDX_W-1:0]      alloc_idx,
	output logic                   dec_issue,
	output logic [`IDX_W-1:0]      dec_idx,
	output logic                   ex_issue,
	output logic [`IDX_W-1:0]      ex_idx,
	output logic                   retire_fire,
	output logic [`IDX_W-1:0]      retire_idx
);

	// Age relative to the head, immune to counter wrap
	logic [`SNS_W-1:0] age [`ROB_ENTRIES];

	always_comb begin
		for (int i = 0; i < `ROB_ENTRIES; i++)
			age[i] = sns_arr[i] - head_sns;
	end

	// ========================================
	// Allocate and decode
	// ========================================
	// Lowest free slot, scan from the top so the last hit wins
	always_comb begin
		alloc_idx = `IDX_NONE;
		for (int i = `ROB_ENTRIES-1; i >= 0; i--)
			if (!valid_vec[i])
				alloc_idx = `IDX_W'(i);
	end

	// Decode order does not matter, lowest waiting entry
	always_comb begin
		dec_idx = `IDX_NONE;
		for (int i = `ROB_ENTRIES-1; i >= 0; i--)
			if (valid_vec[i] && !decoded_vec[i] && !out_vec[i])
				dec_idx = `IDX_W'(i);
		dec_issue = dec_ready && (dec_idx != `IDX_NONE);
	end

	// ========================================
	// Execute
	// ========================================
	// Oldest ready entry whose arguments are final in the register file
	always_comb begin
		logic hazard;
		ex_idx = `IDX_NONE;
		for (int i = 0; i < `ROB_ENTRIES; i++) begin
			hazard = 1'b0;
			for (int j = 0; j < `ROB_ENTRIES; j++) begin
				if (valid_vec[j] && age[j] < age[i]) begin
					// Older undecoded entry, writes and memory use unknown
					if (!decoded_vec[j])
						hazard = 1'b1;
					// Source still owed by an older unretired writer
					if (|(dst_mask_arr[j] & src_mask_arr[i]))
						hazard = 1'b1;
					// Memory operations go strictly in program order
					if (is_mem_vec[i] && is_mem_vec[j] && !executed_vec[j])
						hazard = 1'b1;
				end
			end
			if (valid_vec[i] && decoded_vec[i] && !executed_vec[i] && !out_vec[i] &&
			    !hazard && (ex_idx == `IDX_NONE || age[i] < age[ex_idx]))
				ex_idx = `IDX_W'(i);
		end
		ex_issue = ex_ready && (ex_idx != `IDX_NONE);
	end

	// ========================================
	// Retire
	// ========================================
	// Head entry only, once its result is in
	always_comb begin
		retire_idx = `IDX_NONE;
		for (int i = 0; i < `ROB_ENTRIES; i++)
			if (valid_vec[i] && sns_arr[i] == head_sns)
				retire_idx = `IDX_W'(i);
		retire_fire = (retire_idx != `IDX_NONE) && executed_vec[retire_idx];
	end

	// Executor picks lie inside the live window of sequence numbers
	// No live entry is ever executed without decoded fields
	always_comb begin
		if (ex_issue)
			a_ex_decoded: assert (age[ex_idx] < `SNS_W'(`ROB_ENTRIES) &&
				(valid_vec & executed_vec & ~decoded_vec) == '0);
	end

endmodule

`default_nettype wire

/* ooo_engine.f */
+incdir+logic
logic/ooo_pkg.sv
logic/rob_store.sv
logic/stage_scheduler.sv
logic/decode_unit.sv
logic/execute_unit.sv
logic/rob_update_arbiter.sv
logic/ooo_engine_top.sv
sim/ooo_checker.sv
sim/tb_ooo_engine.sv

/* sim/ooo_checker.sv */
// Scoreboard for the out-of-order engine
// Records each accepted instruction, runs it in program order on a model
// register file and data memory, and checks every retirement against it
`timescale 1ns/1ps
`default_nettype none
`include "ooo_settings.svh"

module ooo_checker
	import ooo_pkg::*;
(
	input  wire               clk,
	input  wire               rst_n,
	input  wire               in_valid,
	input  wire [15:0]        in_instr,
	input  wire               rob_full,
	input  wire               retire_valid,
	input  wire [2:0]         retire_dst,
	input  wire               retire_we,
	input  wire [`DATA_W-1:0] retire_data,
	output int                error_count,
	output int                retire_count,
	output int                accept_count,
	output int                pending
);

	// Architectural model
	logic [`DATA_W-1:0] model_regs [`NUM_REGS];
	logic [`DATA_W-1:0] model_mem  [`DMEM_WORDS];
	// Accepted words in program order, with their acceptance cycle
	logic [15:0]        instr_q [$];
	int                 accept_cyc_q [$];
	int                 cycle;

	// ========================================
	// Reference model
	// ========================================
	// One instruction in program order, returns {we, dst, data}
	function automatic logic [`DATA_W+3:0] run_reference(input logic [15:0] word);
		instr_u             w;
		logic [`DATA_W-1:0] a;
		logic [`DATA_W-1:0] b;
		logic [`DATA_W-1:0] imm;
		logic [`DATA_W-1:0] data;
		logic [3:0]         addr;
		logic [2:0]         dst;
		logic               we;
		w    = word;
		a    = model_regs[w.imm_fmt.src_a];
		b    = model_regs[w.reg_fmt.src_b];
		imm  = {{(`DATA_W-7){w.imm_fmt.offset[6]}}, w.imm_fmt.offset};
		// Low 4 bits of the base register plus the offset
		addr = a[3:0] + imm[3:0];
		// reg_fmt.dst and imm_fmt.reg_field share bits 12:10
		dst  = w.imm_fmt.reg_field;
		we   = 1'b1;
		case (w.reg_fmt.opcode)
			ADDI:  data = a + imm;
			ADD:   data = a + b;
			SUB:   data = a - b;
			XOR:   data = a ^ b;
			LOAD:  data = model_mem[addr];
			STORE: begin
				data = model_regs[w.imm_fmt.reg_field];
				model_mem[addr] = data;
				we = 1'b0;
			end
			// NOP codes
			default: begin
				data = '0;
				we = 1'b0;
			end
		endcase
		if (we)
			model_regs[dst] = data;
		return {we, dst, data};
	endfunction

	// ========================================
	// Acceptance and retirement compare
	// ========================================
	always @(posedge clk) begin : compare
		logic [15:0]        word;
		logic               exp_we;
		logic [2:0]         exp_dst;
		logic [`DATA_W-1:0] exp_data;
		int                 acc_cyc;
		int                 occupied;
		if (!rst_n) begin
			for (int i = 0; i < `NUM_REGS; i++)
				model_regs[i] = '0;
			for (int i = 0; i < `DMEM_WORDS; i++)
				model_mem[i] = '0;
			instr_q.delete();
			accept_cyc_q.delete();
			error_count  = 0;
			retire_count = 0;
			accept_count = 0;
			pending      = 0;
			cycle        = 0;
		end else begin
			cycle++;
			// Buffer is full when six unretired instructions hold entries
			// An entry behind a visible retire_valid was freed one edge earlier
			occupied = instr_q.size() - (retire_valid ? 1 : 0);
			if (rob_full !== (occupied == `ROB_ENTRIES)) begin
				$display("Mismatch at %0t: rob_full expected %b got %b",
					$time, occupied == `ROB_ENTRIES, rob_full);
				error_count++;
			end
			// Older than anything accepted at this same edge
			if (retire_valid) begin
				retire_count++;
				if (instr_q.size() == 0) begin
					$display("Error at %0t: retirement with no instruction pending", $time);
					error_count++;
				end else begin
					word    = instr_q.pop_front();
					acc_cyc = accept_cyc_q.pop_front();
					{exp_we, exp_dst, exp_data} = run_reference(word);
					// retire_valid rose one edge before it is seen here
					if (cycle - acc_cyc < 5) begin
						$display("Error at %0t: instruction %h retired under 4 cycles after acceptance",
							$time, word);
						error_count++;
					end
					if (retire_we !== exp_we) begin
						$display("Mismatch at %0t: retire_we expected %b got %b",
							$time, exp_we, retire_we);
						error_count++;
					end
					if (exp_we && retire_dst !== exp_dst) begin
						$display("Mismatch at %0t: retire_dst expected %0d got %0d",
							$time, exp_dst, retire_dst);
						error_count++;
					end
					// Stores report their data, NOPs carry nothing
					if ((exp_we || word[15:13] == STORE) && retire_data !== exp_data) begin
						$display("Mismatch at %0t: retire_data expected %h got %h",
							$time, exp_data, retire_data);
						error_count++;
					end
				end
			end
			if (in_valid && !rob_full) begin
				instr_q.push_back(in_instr);
				accept_cyc_q.push_back(cycle);
				accept_count++;
			end
			pending = instr_q.size();
		end
	end

endmodule

`default_nettype wire

/* sim/tb_ooo_engine.sv */
// Testbench for the out-of-order engine
// Issues directed programs and a seeded random mix one instruction per cycle,
// holding a word while rob_full is high; the checker judges each retirement
`timescale 1ns/1ps
`default_nettype none
`include "ooo_settings.svh"

module tb_ooo_engine
	import ooo_pkg::*;
();

	// Directed programs 7 + 8 + 10 + 12, then 200 random
	localparam int TOTAL_INSTR = 237;
	localparam int CYCLE_LIMIT = 20 * TOTAL_INSTR + 200;

	logic              clk;
	logic              rst_n;
	logic              in_valid;
	logic [15:0]       in_instr;
	wire               rob_full;
	wire               retire_valid;
	wire [2:0]         retire_dst;
	wire               retire_we;
	wire [`DATA_W-1:0] retire_data;
	int                error_count;
	int                retire_count;
	int                accept_count;
	int                pending;
	int                tb_errors;
	int                sent_count;
	int                stall_count;
	int                cycles;

	ooo_engine_top dut0 (
		.clk, .rst_n, .in_valid, .in_instr, .rob_full,
		.retire_valid, .retire_dst, .retire_we, .retire_data
	);

	ooo_checker u_checker (
		.clk, .rst_n, .in_valid, .in_instr, .rob_full,
		.retire_valid, .retire_dst, .retire_we, .retire_data,
		.error_count, .retire_count, .accept_count, .pending
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ========================================
	// Encoding and stimulus helpers
	// ========================================
	function automatic logic [15:0] pack_reg(input opcode_e op, input logic [2:0] d,
		input logic [2:0] a, input logic [2:0] b);
		return {op, d, a, b, 4'b0000};
	endfunction

	function automatic logic [15:0] pack_imm(input opcode_e op, input logic [2:0] r,
		input logic [2:0] a, input logic [6:0] off);
		return {op, r, a, off};
	endfunction

	// Called 1 ns after an edge; rob_full seen now holds at the next edge
	task automatic send(input logic [15:0] word);
		logic taken;
		in_valid = 1'b1;
		in_instr = word;
		taken = 1'b0;
		while (!taken) begin
			taken = !rob_full;
			if (!taken)
				stall_count++;
			@(posedge clk);
			#1;
		end
		in_valid = 1'b0;
		sent_count++;
	endtask

	// Wait for every sent instruction to retire
	task automatic drain();
		while (pending != 0 || sent_count != accept_count) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic print_summary();
		$display("Errors: %0d, retirements: %0d, accepted: %0d",
			error_count + tb_errors, retire_count, accept_count);
	endtask

	// Cycle limit from the instruction count
	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout after %0d cycles, the engine stopped retiring", cycles);
		print_summary();
		$display("Regression failed");
		$finish;
	end

	// ========================================
	// Programs
	// ========================================
	initial begin
		rst_n       = 1'b0;
		in_valid    = 1'b0;
		in_instr    = '0;
		tb_errors   = 0;
		sent_count  = 0;
		stall_count = 0;
		// One seed for the whole run
		void'($urandom(32'h97b));
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
		if (rob_full || retire_valid) begin
			$display("Error: rob_full or retire_valid high after reset");
			tb_errors++;
		end

		// Independent ALU work off r0
		send(pack_imm(ADDI, 3'd1, 3'd0, 7'd5));
		send(pack_imm(ADDI, 3'd2, 3'd0, 7'h7d));
		send(pack_imm(ADDI, 3'd3, 3'd0, 7'd63));
		send(pack_imm(ADDI, 3'd4, 3'd0, 7'd12));
		send(pack_reg(ADD, 3'd5, 3'd1, 3'd2));
		send(pack_reg(SUB, 3'd6, 3'd3, 3'd4));
		send(pack_reg(XOR, 3'd7, 3'd1, 3'd3));
		drain();

		// Dependent chain, each step reads the one before
		send(pack_imm(ADDI, 3'd1, 3'd1, 7'd1));
		send(pack_reg(ADD, 3'd2, 3'd1, 3'd1));
		send(pack_reg(SUB, 3'd3, 3'd2, 3'd1));
		send(pack_reg(XOR, 3'd4, 3'd3, 3'd2));
		send(pack_reg(ADD, 3'd1, 3'd4, 3'd3));
		send(pack_imm(ADDI, 3'd1, 3'd1, 7'h7f));
		send(pack_reg(SUB, 3'd5, 3'd1, 3'd5));
		send(pack_reg(XOR, 3'd6, 3'd6, 3'd5));
		drain();

		// Stores and loads, same and different addresses
		send(pack_imm(STORE, 3'd1, 3'd0, 7'd3));
		send(pack_imm(STORE, 3'd2, 3'd0, 7'd5));
		send(pack_imm(LOAD, 3'd7, 3'd0, 7'd3));
		send(pack_imm(STORE, 3'd3, 3'd0, 7'd3));
		send(pack_imm(LOAD, 3'd6, 3'd0, 7'd3));
		send(pack_imm(LOAD, 3'd5, 3'd0, 7'd5));
		send(pack_imm(ADDI, 3'd4, 3'd0, 7'd9));
		send(pack_imm(STORE, 3'd4, 3'd4, 7'h7e));
		send(pack_imm(LOAD, 3'd3, 3'd0, 7'd7));
		send(pack_imm(LOAD, 3'd2, 3'd4, 7'h7c));
		drain();

		// Back-to-back burst of two chains, long enough to fill the buffer
		begin
			int stalls_before;
			stalls_before = stall_count;
			for (int i = 0; i < 12; i++)
				send(pack_imm(ADDI, 3'(i % 2 + 1), 3'(i % 2 + 1), 7'(i)));
			if (stall_count == stalls_before) begin
				$display("Error: burst never saw rob_full high");
				tb_errors++;
			end
		end
		drain();

		// Random mix with occasional idle cycles, NOP codes included
		for (int i = 0; i < 200; i++) begin
			if ($urandom % 4 == 0) begin
				@(posedge clk);
				#1;
			end
			send(16'($urandom));
		end
		drain();

		// Quiet tail, any late retirement is flagged by the checker
		repeat (20) @(posedge clk);
		#1;
		if (retire_count != accept_count) begin
			$display("Error: accepted %0d but retired %0d instructions",
				accept_count, retire_count);
			tb_errors++;
		end
		print_summary();
		if (error_count + tb_errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire
